// ==== video_pkg.sv ====
`default_nettype none

package video_pkg;

    // Raster geometry in pixels per line
    localparam int h_total      = 512;
    localparam int h_active     = 384;
    localparam int h_sync_start = 416;
    localparam int h_sync_end   = 448;

    // Raster geometry in lines per frame
    localparam int v_total      = 262;
    localparam int v_active     = 224;
    localparam int v_sync_start = 236;
    localparam int v_sync_end   = 239;

    typedef logic [8:0] count_t;

    // One pixel from a layer stream
    typedef struct packed {
        logic [3:0] grp;
        logic [3:0] idx;
    } layer_pxl_t;

    localparam logic [3:0] transparent_idx = 4'hf;

    localparam int num_layers = 4;
    typedef logic [1:0] layer_id_t;

    // Layer number, group, index
    typedef logic [9:0] pal_addr_t;
    localparam pal_addr_t backdrop_addr = '1;
    localparam int pal_entries = 1024;

    // RGB444 palette entry
    typedef logic [11:0] pal_color_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // Layer input to RGB output
    localparam int pix_delay = 2;

    typedef struct packed {
        logic hblank;
        logic vblank;
        logic hsync;
        logic vsync;
    } blank_t;

endpackage

`default_nettype wire

// ==== regs_pkg.sv ====
`default_nettype none

package regs_pkg;

    import video_pkg::*;

    // Register byte offsets
    localparam logic [12:0] reg_layer_ctrl  = 13'h000;
    localparam logic [12:0] reg_layer_en    = 13'h004;
    localparam logic [12:0] reg_raster_line = 13'h008;
    localparam logic [12:0] reg_status      = 13'h00c;

    // Palette window select
    localparam int pal_window_bit = 12;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [12:0] paddr;
        logic [15:0] pwdata;
    } apb_req_t;

    // Field 0 draws at the bottom, field 3 on top
    typedef layer_id_t [3:0] layer_order_t;

    typedef struct packed {
        layer_order_t order;
        logic [3:0]   layer_en;
        count_t       raster_line;
    } video_cfg_t;

    typedef struct packed {
        logic       we;
        pal_addr_t  addr;
        pal_color_t color;
    } pal_wr_t;

endpackage

`default_nettype wire

// ==== video_delay.sv ====
`default_nettype none

module video_delay #(
    parameter type payload_t = logic,
    parameter int  depth     = 2
) (
    input  wire      clk,
    input  wire      rst,
    input  payload_t din,
    output payload_t dout
);

    payload_t stages [depth];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < depth; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= din;
            for (int i = 1; i < depth; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign dout = stages[depth-1];

endmodule

`default_nettype wire

// ==== video_timing.sv ====
`default_nettype none

module video_timing (
    input  wire                clk,
    input  wire                rst,
    output video_pkg::count_t  hcount,
    output video_pkg::count_t  vcount,
    output logic               line_start,
    output video_pkg::blank_t  blank
);

    import video_pkg::*;

    logic h_last;
    logic v_last;

    assign h_last = (hcount == count_t'(h_total - 1));
    assign v_last = (vcount == count_t'(v_total - 1));

    // Line counter only moves on the last pixel of a line
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
        end else begin
            if (h_last) begin
                hcount <= '0;
                if (v_last) begin
                    vcount <= '0;
                end else begin
                    vcount <= vcount + 9'd1;
                end
            end else begin
                hcount <= hcount + 9'd1;
            end
        end
    end

    assign line_start = (hcount == '0);

    // Blanking past the visible area
    assign blank.hblank = (hcount >= count_t'(h_active));
    assign blank.vblank = (vcount >= count_t'(v_active));

    // Sync pulses sit inside the blanking
    assign blank.hsync = (hcount >= count_t'(h_sync_start))
                      && (hcount <  count_t'(h_sync_end));
    assign blank.vsync = (vcount >= count_t'(v_sync_start))
                      && (vcount <  count_t'(v_sync_end));

endmodule

`default_nettype wire

// ==== video_regs.sv ====
`default_nettype none

module video_regs (
    input  wire                    clk,
    input  wire                    rst,
    input  regs_pkg::apb_req_t     apb,
    output logic [15:0]            prdata,
    output logic                   pslverr,
    input  video_pkg::count_t      vcount,
    input  wire                    line_start,
    output regs_pkg::video_cfg_t   cfg,
    output regs_pkg::pal_wr_t      pal_wr,
    output logic                   raster
);

    import regs_pkg::*;

    logic access;
    logic in_window;
    logic mapped;
    logic wr_en;
    logic rd_en;

    // Access phase of a transfer
    assign access    = apb.psel && apb.penable;
    assign in_window = apb.paddr[pal_window_bit];
    assign wr_en     = access && apb.pwrite;
    assign rd_en     = access && !apb.pwrite;

    assign mapped = (apb.paddr == reg_layer_ctrl)
                 || (apb.paddr == reg_layer_en)
                 || (apb.paddr == reg_raster_line)
                 || (apb.paddr == reg_status);

    // Error on unmapped offsets and on writes to the read-only status
    assign pslverr = access && !in_window
                  && (!mapped || (apb.pwrite && apb.paddr == reg_status));

    // Read data is valid in the access cycle
    always_comb begin
        prdata = '0;
        if (rd_en && !in_window) begin
            case (apb.paddr)
                reg_layer_ctrl:  prdata[7:0] = cfg.order;
                reg_layer_en:    prdata[3:0] = cfg.layer_en;
                reg_raster_line: prdata[8:0] = cfg.raster_line;
                reg_status:      prdata[8:0] = vcount;
                default:         prdata = '0;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg <= '0;
        end else if (wr_en && !in_window) begin
            case (apb.paddr)
                reg_layer_ctrl:  cfg.order       <= apb.pwdata[7:0];
                reg_layer_en:    cfg.layer_en    <= apb.pwdata[3:0];
                reg_raster_line: cfg.raster_line <= apb.pwdata[8:0];
                default: ;
            endcase
        end
    end

    // Palette entries sit on a 4-byte stride, so address bits 11:2 pick the entry
    assign pal_wr.we    = wr_en && in_window;
    assign pal_wr.addr  = apb.paddr[11:2];
    assign pal_wr.color = apb.pwdata[11:0];

    // Pulse on the pixel after the start of the programmed line
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            raster <= 1'b0;
        end else begin
            raster <= line_start && (vcount == cfg.raster_line);
        end
    end

endmodule

`default_nettype wire

// ==== layer_mixer.sv ====
`default_nettype none

module layer_mixer (
    input  wire                    clk,
    input  wire                    rst,
    input  video_pkg::layer_pxl_t  [video_pkg::num_layers-1:0] layer_pxl,
    input  regs_pkg::video_cfg_t   cfg,
    output video_pkg::pal_addr_t   pal_addr
);

    import video_pkg::*;

    pal_addr_t  sel_addr;
    logic       found;
    layer_id_t  id;
    layer_pxl_t pxl;

    // Top-down search through the draw order
    always_comb begin
        sel_addr = backdrop_addr;
        found    = 1'b0;
        id       = '0;
        pxl      = '0;
        for (int i = num_layers - 1; i >= 0; i--) begin
            id  = cfg.order[i];
            pxl = layer_pxl[id];
            if (!found && cfg.layer_en[id] && pxl.idx != transparent_idx) begin
                found    = 1'b1;
                sel_addr = {id, pxl.grp, pxl.idx};
            end
        end
    end

    // A real pixel never has index 15, so it cannot alias the backdrop entry
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pal_addr <= backdrop_addr;
        end else begin
            pal_addr <= sel_addr;
        end
    end

endmodule

`default_nettype wire

// ==== palette_ram.sv ====
`default_nettype none

module palette_ram (
    input  wire                   clk,
    input  regs_pkg::pal_wr_t     pal_wr,
    input  video_pkg::pal_addr_t  pal_addr,
    input  video_pkg::blank_t     blank,
    output video_pkg::rgb_t       rgb
);

    import video_pkg::*;

    pal_color_t mem [pal_entries];

    // Repeat each nibble to fill 8 bits
    function automatic rgb_t expand(input pal_color_t c);
        rgb_t v;
        v.r = {c[11:8], c[11:8]};
        v.g = {c[7:4], c[7:4]};
        v.b = {c[3:0], c[3:0]};
        return v;
    endfunction

    always_ff @(posedge clk) begin
        if (pal_wr.we) begin
            mem[pal_wr.addr] <= pal_wr.color;
        end
    end

    // Same-cycle write leaves the old entry on the read side
    always_ff @(posedge clk) begin
        if (blank.hblank || blank.vblank) begin
            rgb <= '0;
        end else begin
            rgb <= expand(mem[pal_addr]);
        end
    end

endmodule

`default_nettype wire

// ==== cps_video_top.sv ====
`default_nettype none

module cps_video_top (
    input  wire                    clk,
    input  wire                    rst,
    input  regs_pkg::apb_req_t     apb,
    input  video_pkg::layer_pxl_t  [video_pkg::num_layers-1:0] layer_pxl,
    output logic [15:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    output video_pkg::count_t      hcount,
    output video_pkg::count_t      vcount,
    output logic                   raster,
    output video_pkg::blank_t      blank_out,
    output video_pkg::rgb_t        rgb
);

    import video_pkg::*;
    import regs_pkg::*;

    blank_t     blank;
    blank_t     blank_pal;
    logic       line_start;
    video_cfg_t cfg;
    pal_wr_t    pal_wr;
    pal_addr_t  pal_addr;

    // Zero wait states
    assign pready = 1'b1;

    video_timing u_timing (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .hcount     ( hcount     ),
        .vcount     ( vcount     ),
        .line_start ( line_start ),
        .blank      ( blank      )
    );

    video_regs u_regs (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .apb        ( apb        ),
        .prdata     ( prdata     ),
        .pslverr    ( pslverr    ),
        .vcount     ( vcount     ),
        .line_start ( line_start ),
        .cfg        ( cfg        ),
        .pal_wr     ( pal_wr     ),
        .raster     ( raster     )
    );

    layer_mixer u_mixer (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .layer_pxl  ( layer_pxl  ),
        .cfg        ( cfg        ),
        .pal_addr   ( pal_addr   )
    );

    // Blanking lined up with the registered palette address
    video_delay #(
        .payload_t  ( blank_t        ),
        .depth      ( pix_delay - 1  )
    ) u_pal_blank_dly (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .din        ( blank      ),
        .dout       ( blank_pal  )
    );

    palette_ram u_palette (
        .clk        ( clk        ),
        .pal_wr     ( pal_wr     ),
        .pal_addr   ( pal_addr   ),
        .blank      ( blank_pal  ),
        .rgb        ( rgb        )
    );

    // Flags matched to the full pixel latency
    video_delay #(
        .payload_t  ( blank_t    ),
        .depth      ( pix_delay  )
    ) u_blank_dly (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .din        ( blank      ),
        .dout       ( blank_out  )
    );

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset held over the first two rising edges
    initial begin
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== tb_cps_video.sv ====
`default_nettype none

module tb_cps_video;

    timeunit 1ns;
    timeprecision 1ps;

    import video_pkg::*;
    import regs_pkg::*;

    typedef struct packed {
        logic [12:0] addr;
        logic [15:0] wdata;
        logic [15:0] rdata;
    } reg_row_t;

    // Pixels packed as {l3, l2, l1, l0} and winner 4 for the backdrop
    typedef struct packed {
        layer_order_t order;
        logic [3:0]   en;
        logic [31:0]  pix;
        logic [2:0]   win;
    } prio_row_t;

    logic             clk;
    logic             rst;
    apb_req_t         apb;
    layer_pxl_t [3:0] layer_pxl;
    logic [15:0]      prdata;
    logic             pready;
    logic             pslverr;
    count_t           hcount;
    count_t           vcount;
    logic             raster;
    blank_t           blank_out;
    rgb_t             rgb;

    reg_row_t reg_tab [6] = '{
        '{reg_layer_ctrl,  16'hffff, 16'h00ff},
        '{reg_layer_en,    16'hffff, 16'h000f},
        '{reg_raster_line, 16'hffff, 16'h01ff},
        '{reg_layer_ctrl,  16'h12e4, 16'h00e4},
        '{reg_layer_en,    16'ha5a5, 16'h0005},
        '{reg_raster_line, 16'h0355, 16'h0155}
    };

    // Last two rows have no visible layer
    prio_row_t prio_tab [8] = '{
        '{8'he4, 4'hf, 32'h78563412, 3'd3},
        '{8'he4, 4'hf, 32'h7f563412, 3'd2},
        '{8'h1b, 4'hf, 32'h78563412, 3'd0},
        '{8'h1b, 4'he, 32'h78563412, 3'd1},
        '{8'he4, 4'h5, 32'h785f3412, 3'd0},
        '{8'h4e, 4'hf, 32'h78563f1f, 3'd3},
        '{8'he4, 4'hf, 32'h7f5f3f1f, 3'd4},
        '{8'he4, 4'h0, 32'h78563412, 3'd4}
    };

    logic [11:0]  model_pal [pal_entries];
    layer_order_t m_order;
    logic [3:0]   m_en;
    logic [31:0]  rng = 32'd99;
    rgb_t         exp_q [$];
    int           errors = 0;
    int           mark = 0;
    int           tests = 0;
    int           failed = 0;

    tb_clock u_clock (
        .clk ( clk ),
        .rst ( rst )
    );

    cps_video_top u_cps_video_top (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic rgb_t expand_color(input logic [11:0] c);
        return {c[11:8], c[11:8], c[7:4], c[7:4], c[3:0], c[3:0]};
    endfunction

    // Bottom field first so that a later qualifying layer overrides
    function automatic rgb_t predict_rgb(input layer_pxl_t [3:0] px);
        pal_addr_t a;
        layer_id_t l;
        a = backdrop_addr;
        for (int f = 0; f < num_layers; f++) begin
            l = m_order[f];
            if (m_en[l] && px[l].idx != transparent_idx) a = {l, px[l]};
        end
        return expand_color(model_pal[a]);
    endfunction

    task automatic report_mismatch(input string msg, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("MISMATCH at %0t ns: %s expected %h got %h", $time, msg, exp, got);
        errors++;
    endtask

    task automatic close_test(input string name);
        tests++;
        if (errors != mark) begin
            failed++;
            $display("test %s: failed with %0d errors", name, errors - mark);
        end else begin
            $display("test %s: passed", name);
        end
        mark = errors;
    endtask

    // Setup cycle and then an access cycle held until pready
    task automatic apb_access(input logic wr, input logic [12:0] addr,
                              input logic [15:0] wdata, input logic exp_err,
                              output logic [15:0] rdata, output count_t vc);
        apb_req_t r;
        int       n;
        r = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apb <= r;
        r.penable = 1'b1;
        @(posedge clk);
        apb <= r;
        n = 0;
        @(negedge clk);
        while (!pready && n < 16) begin
            @(negedge clk);
            n++;
        end
        if (!pready) begin
            $display("APB transfer to %h never completed", addr);
            errors++;
        end
        if (pslverr != exp_err) report_mismatch("pslverr", 32'(exp_err), 32'(pslverr));
        rdata = prdata;
        vc = vcount;
        @(posedge clk);
        apb <= '0;
    endtask

    task automatic apb_write(input logic [12:0] addr, input logic [15:0] data,
                             input logic exp_err);
        logic [15:0] rd;
        count_t      vc;
        apb_access(1'b1, addr, data, exp_err, rd, vc);
    endtask

    task automatic apb_read(input logic [12:0] addr, input logic exp_err,
                            output logic [15:0] rd, output count_t vc);
        apb_access(1'b0, addr, 16'h0000, exp_err, rd, vc);
    endtask

    task automatic set_layers(input layer_order_t order, input logic [3:0] en);
        apb_write(reg_layer_ctrl, 16'(order), 1'b0);
        apb_write(reg_layer_en, 16'(en), 1'b0);
        m_order = order;
        m_en = en;
    endtask

    // Wait for visible video with room for a burst of pixels on the line
    task automatic wait_active(input int room);
        int n;
        n = 0;
        @(negedge clk);
        while (!(hcount + room < h_active && vcount < v_active) && n < 150000) begin
            @(negedge clk);
            n++;
        end
        if (n >= 150000) begin
            $display("Active video never came");
            errors++;
        end
    endtask

    // Each rgb sample belongs to the pixel driven pix_delay cycles earlier
    task automatic drive_pixel(input layer_pxl_t [3:0] px, input rgb_t exp);
        rgb_t e;
        @(posedge clk);
        layer_pxl <= px;
        exp_q.push_back(exp);
        @(negedge clk);
        if (exp_q.size() > pix_delay) begin
            e = exp_q.pop_front();
            if (blank_out.hblank || blank_out.vblank) e = '0;
            if (rgb != e) report_mismatch("rgb", 32'(e), 32'(rgb));
        end
    endtask

    initial begin
        logic [15:0]      rd;
        count_t           vc;
        layer_pxl_t [3:0] px;
        pal_addr_t        a;
        int               hist [$];
        int               vhist [$];
        int               h;
        int               v;
        logic             exp_hs;
        logic             exp_vs;
        int               n;
        apb       <= '0;
        layer_pxl <= '0;
        n = 0;
        @(negedge clk);
        while (rst && n < 8) begin
            @(negedge clk);
            n++;
        end
        if (rst) begin
            $display("Reset was never released");
            errors++;
        end

        foreach (reg_tab[i]) begin
            apb_write(reg_tab[i].addr, reg_tab[i].wdata, 1'b0);
            apb_read(reg_tab[i].addr, 1'b0, rd, vc);
            if (rd != reg_tab[i].rdata)
                report_mismatch("readback", 32'(reg_tab[i].rdata), 32'(rd));
        end
        apb_write(reg_status, 16'h1234, 1'b1);
        apb_read(13'h010, 1'b1, rd, vc);
        apb_read(13'h1008, 1'b0, rd, vc);
        if (rd != '0) report_mismatch("palette window read", 32'h0, 32'(rd));
        // Let the line counter move off zero before reading status
        n = 0;
        @(negedge clk);
        while (vcount < 9'd3 && n < 4 * h_total) begin
            @(negedge clk);
            n++;
        end
        if (vcount < 9'd3) begin
            $display("Line counter never advanced");
            errors++;
        end
        apb_read(reg_status, 1'b0, rd, vc);
        if (rd != 16'(vc)) report_mismatch("status line counter", 32'(vc), 32'(rd));
        close_test("registers");

        for (int e = 0; e < pal_entries; e++) begin
            rng = xorshift(rng);
            model_pal[e] = rng[11:0];
            apb_write({1'b1, 10'(e), 2'b00}, {4'h0, rng[11:0]}, 1'b0);
        end
        for (int l = 0; l < num_layers; l++) begin
            set_layers(8'he4, 4'(1 << l));
            wait_active(80);
            exp_q.delete();
            repeat (64) begin
                rng = xorshift(rng);
                px = rng;
                if (px[l].idx == transparent_idx) px[l].idx = 4'h0;
                drive_pixel(px, predict_rgb(px));
            end
        end
        close_test("palette");

        foreach (prio_tab[i]) begin
            if (i == 6) close_test("priority");
            set_layers(prio_tab[i].order, prio_tab[i].en);
            px = prio_tab[i].pix;
            a = prio_tab[i].win[2] ? backdrop_addr
                                   : {prio_tab[i].win[1:0], px[prio_tab[i].win[1:0]]};
            wait_active(8);
            exp_q.delete();
            repeat (4) drive_pixel(px, expand_color(model_pal[a]));
        end
        close_test("backdrop");

        // One full frame, starting at the first pixel of a line
        n = 0;
        @(negedge clk);
        while (hcount != '0 && n < h_total) begin
            @(negedge clk);
            n++;
        end
        if (hcount != '0) begin
            $display("Line start never came");
            errors++;
        end
        repeat (h_total * v_total + pix_delay) begin
            hist.push_back(int'(hcount));
            vhist.push_back(int'(vcount));
            if (hist.size() > pix_delay) begin
                h = hist.pop_front();
                v = vhist.pop_front();
                exp_hs = (h >= h_sync_start) && (h < h_sync_end);
                exp_vs = (v >= v_sync_start) && (v < v_sync_end);
                if (blank_out.hblank != (h >= h_active))
                    report_mismatch("delayed hblank", 32'(h >= h_active), 32'(blank_out.hblank));
                if (blank_out.vblank != (v >= v_active))
                    report_mismatch("delayed vblank", 32'(v >= v_active), 32'(blank_out.vblank));
                if (blank_out.hsync != exp_hs)
                    report_mismatch("delayed hsync", 32'(exp_hs), 32'(blank_out.hsync));
                if (blank_out.vsync != exp_vs)
                    report_mismatch("delayed vsync", 32'(exp_vs), 32'(blank_out.vsync));
            end
            if ((blank_out.hblank || blank_out.vblank) && rgb != '0)
                report_mismatch("rgb during blanking", 32'h0, 32'(rgb));
            @(negedge clk);
        end
        close_test("blanking");

        apb_write(reg_raster_line, 16'd100, 1'b0);
        n = 0;
        @(negedge clk);
        while (!raster && n < 150000) begin
            @(negedge clk);
            n++;
        end
        if (!raster) begin
            $display("Raster pulse never came");
            errors++;
        end else begin
            if (vcount != 9'd100) report_mismatch("raster vcount", 32'd100, 32'(vcount));
            if (hcount != 9'd1) report_mismatch("raster hcount", 32'd1, 32'(hcount));
            @(negedge clk);
            if (raster) report_mismatch("raster width", 32'h0, 32'(raster));
        end
        close_test("raster");

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
video_pkg.sv
regs_pkg.sv
video_delay.sv
video_timing.sv
video_regs.sv
layer_mixer.sv
palette_ram.sv
cps_video_top.sv
tb_clock.sv
tb_cps_video.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f src.f \
    --top-module tb_cps_video -o tb_cps_video
./obj_dir/tb_cps_video | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
